/* Makefile */
# Verilator build and run for the AXI4 bandwidth throttler

VERILATOR ?= verilator
TOP       ?= tb_mem_bw_throttler
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal
PASS_MSG  ?= NO ERRORS

SOURCES := $(wildcard design/*.sv design/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides pass or fail
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/mem_bw_throttler.sv */
`default_nettype none

`include "throttle_params.svh"

module mem_bw_throttler (
    input  logic                   aclk,
    input  logic                   aresetn,
    // Master side
    input  throttle_pkg::ax_req_t  s_aw,
    input  logic                   s_awvalid,
    output logic                   s_awready,
    input  throttle_pkg::w_beat_t  s_w,
    input  logic                   s_wvalid,
    output logic                   s_wready,
    output throttle_pkg::b_resp_t  s_b,
    output logic                   s_bvalid,
    input  logic                   s_bready,
    input  throttle_pkg::ax_req_t  s_ar,
    input  logic                   s_arvalid,
    output logic                   s_arready,
    output throttle_pkg::r_beat_t  s_r,
    output logic                   s_rvalid,
    input  logic                   s_rready,
    // Slave side
    output throttle_pkg::ax_req_t  m_aw,
    output logic                   m_awvalid,
    input  logic                   m_awready,
    output throttle_pkg::w_beat_t  m_w,
    output logic                   m_wvalid,
    input  logic                   m_wready,
    input  throttle_pkg::b_resp_t  m_b,
    input  logic                   m_bvalid,
    output logic                   m_bready,
    output throttle_pkg::ax_req_t  m_ar,
    output logic                   m_arvalid,
    input  logic                   m_arready,
    input  throttle_pkg::r_beat_t  m_r,
    input  logic                   m_rvalid,
    output logic                   m_rready,
    // Static bucket configuration
    input  logic [`TOK_INT_W-1:0]  aw_init_token,
    input  logic [`TOK_FRAC_W:0]   aw_upd_token,
    input  logic [`TOK_INT_W-1:0]  ar_init_token,
    input  logic [`TOK_FRAC_W:0]   ar_upd_token
);

    // Payloads pass untouched, only valid/ready get gated
    assign m_aw = s_aw;
    assign m_w  = s_w;
    assign m_ar = s_ar;
    assign s_b  = m_b;
    assign s_r  = m_r;

    // Responses are never throttled
    assign s_bvalid = m_bvalid;
    assign m_bready = s_bready;
    assign s_rvalid = m_rvalid;
    assign m_rready = s_rready;

    write_throttle wr_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .s_aw       (s_aw),
        .s_awvalid  (s_awvalid),
        .s_awready  (s_awready),
        .m_awvalid  (m_awvalid),
        .m_awready  (m_awready),
        .s_wvalid   (s_wvalid),
        .s_wready   (s_wready),
        .s_wlast    (s_w.last),
        .m_wvalid   (m_wvalid),
        .m_wready   (m_wready),
        .m_bvalid   (m_bvalid),
        .s_bready   (s_bready),
        .init_token (aw_init_token),
        .upd_token  (aw_upd_token)
    );

    read_throttle rd_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .s_ar       (s_ar),
        .s_arvalid  (s_arvalid),
        .s_arready  (s_arready),
        .m_arvalid  (m_arvalid),
        .m_arready  (m_arready),
        .rvalid     (m_rvalid),
        .rready     (s_rready),
        .init_token (ar_init_token),
        .upd_token  (ar_upd_token)
    );

endmodule

`default_nettype wire

/* design/read_throttle.sv */
`default_nettype none

`include "throttle_params.svh"

module read_throttle (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  throttle_pkg::ax_req_t s_ar,
    input  logic                  s_arvalid,
    output logic                  s_arready,
    output logic                  m_arvalid,
    input  logic                  m_arready,
    input  logic                  rvalid,
    input  logic                  rready,
    input  logic [`TOK_INT_W-1:0] init_token,
    input  logic [`TOK_FRAC_W:0]  upd_token
);

    import throttle_pkg::*;

    logic   ar_throttled;
    logic   ar_done;
    logic   r_hs;
    token_t r_refund;

    // Blocked AR is invisible to both sides
    assign m_arvalid = s_arvalid && !ar_throttled;
    assign s_arready = m_arready && !ar_throttled;
    assign ar_done   = m_arvalid && m_arready;

    assign r_hs = rvalid && rready;

    token_bucket #(
        .PER_BEAT_COST (`R_TIMEOUT + 1),
        .BASE_COST     (0)
    ) bucket_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .init_token (init_token),
        .upd_token  (upd_token),
        .len        (s_ar.len),
        .req_valid  (s_arvalid),
        .take       (ar_done),
        .sink_ready (m_arready),
        .refund_a   (r_refund),
        .refund_b   ('0),
        .throttled  (ar_throttled)
    );

    // Read beat waiting on the master
    refund_timer #(
        .TIMEOUT (`R_TIMEOUT)
    ) r_timer_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .restart (rready),
        .pending (rvalid),
        .fire    (r_hs),
        .refund  (r_refund)
    );

endmodule

`default_nettype wire

/* design/refund_timer.sv */
`default_nettype none

`include "throttle_params.svh"

module refund_timer #(
    parameter int TIMEOUT = 15
) (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 restart,
    input  logic                 pending,
    input  logic                 fire,
    output throttle_pkg::token_t refund
);

    import throttle_pkg::*;

    localparam int CNT_W = $clog2(TIMEOUT + 1);

    logic [CNT_W-1:0] remain;

    // Counts down while the other side is kept waiting
    always_ff @(posedge aclk) begin
        if (!aresetn || restart) begin
            remain <= CNT_W'(TIMEOUT);
        end else if (pending && remain != '0) begin
            remain <= remain - 1'b1;
        end
    end

    // Whatever is left of the window comes back as whole tokens
    assign refund = fire ? token_t'({remain, {`TOK_FRAC_W{1'b0}}}) : '0;

endmodule

`default_nettype wire

/* design/throttle_params.svh */
`ifndef THROTTLE_PARAMS_SVH
`define THROTTLE_PARAMS_SVH

// AXI4 bus widths
`define AXI_ID_W 4
`define AXI_ADDR_W 32
`define AXI_DATA_W 128

// Token count in fixed point, fraction in the low bits
`define TOK_INT_W 16
`define TOK_FRAC_W 8

// Refund windows in cycles
`define W_TIMEOUT 15
`define B_TIMEOUT 15
`define R_TIMEOUT 15

// AWs accepted ahead of their write data
`define MAX_OUTST_WR 8

`endif

/* design/throttle_pkg.sv */
`default_nettype none

`include "throttle_params.svh"

package throttle_pkg;

    // Token count, integer part on top
    typedef logic [`TOK_INT_W+`TOK_FRAC_W-1:0] token_t;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    // AW and AR payload
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [7:0]             len;
        logic [2:0]             size;
        axi_burst_e             burst;
    } ax_req_t;

    typedef struct packed {
        logic [`AXI_DATA_W-1:0]   data;
        logic [`AXI_DATA_W/8-1:0] strb;
        logic                     last;
    } w_beat_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0] id;
        logic [1:0]           resp;
    } b_resp_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] data;
        logic [1:0]             resp;
        logic                   last;
    } r_beat_t;

endpackage

`default_nettype wire

/* design/token_bucket.sv */
`default_nettype none

`include "throttle_params.svh"

module token_bucket #(
    parameter int PER_BEAT_COST = 16,
    parameter int BASE_COST     = 0
) (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic [`TOK_INT_W-1:0]  init_token,
    input  logic [`TOK_FRAC_W:0]   upd_token,
    input  logic [7:0]             len,
    input  logic                   req_valid,
    input  logic                   take,
    input  logic                   sink_ready,
    input  throttle_pkg::token_t   refund_a,
    input  throttle_pkg::token_t   refund_b,
    output logic                   throttled
);

    import throttle_pkg::*;

    localparam int TOK_W = $bits(token_t);

    token_t                count;
    token_t                bank;
    token_t                inflow;
    token_t                cost;
    token_t                init_full;
    logic [`TOK_INT_W-1:0] cost_int;
    logic [TOK_W:0]        upd;
    logic                  over_init;

    // Whole tokens for the burst about to be issued
    assign cost_int = (`TOK_INT_W'(len) + `TOK_INT_W'(1)) * `TOK_INT_W'(PER_BEAT_COST)
                      + `TOK_INT_W'(BASE_COST);
    assign cost      = {cost_int, {`TOK_FRAC_W{1'b0}}};
    assign init_full = {init_token, {`TOK_FRAC_W{1'b0}}};

    assign throttled = cost > count;
    assign over_init = count > init_full;

    // Refunds plus the fixed refill of this cycle
    assign inflow = refund_a + refund_b + token_t'(upd_token);

    // Withdraw on an accepted request, else deposit the bank
    // extra top bit catches overflow of the deposit
    assign upd = take ? {1'b0, count} - {1'b0, cost}
                      : {1'b0, count} + {1'b0, bank};

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            count <= '0;
        end else if (sink_ready && over_init && !req_valid) begin
            // Idle bucket falls back to its initial fill
            count <= init_full;
        end else if (upd[TOK_W]) begin
            count <= '1;
        end else begin
            count <= upd[TOK_W-1:0];
        end
    end

    // Bank holds its contents while a withdrawal uses the counter
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            bank <= '0;
        end else if (take) begin
            bank <= bank + inflow;
        end else begin
            bank <= inflow;
        end
    end

endmodule

`default_nettype wire

/* design/write_throttle.sv */
`default_nettype none

`include "throttle_params.svh"

module write_throttle (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  throttle_pkg::ax_req_t s_aw,
    input  logic                  s_awvalid,
    output logic                  s_awready,
    output logic                  m_awvalid,
    input  logic                  m_awready,
    input  logic                  s_wvalid,
    output logic                  s_wready,
    input  logic                  s_wlast,
    output logic                  m_wvalid,
    input  logic                  m_wready,
    input  logic                  m_bvalid,
    input  logic                  s_bready,
    input  logic [`TOK_INT_W-1:0] init_token,
    input  logic [`TOK_FRAC_W:0]  upd_token
);

    import throttle_pkg::*;

    logic   aw_throttled;
    logic   wr_full;
    logic   w_open;
    logic   aw_block;
    logic   aw_done;
    logic   w_hs;
    logic   w_last_done;
    logic   b_hs;
    token_t w_refund;
    token_t b_refund;

    // AW held back on low tokens or too many writes awaiting data
    assign aw_block  = aw_throttled || wr_full;
    assign m_awvalid = s_awvalid && !aw_block;
    assign s_awready = m_awready && !aw_block;
    assign aw_done   = m_awvalid && m_awready;

    // W only flows once its AW has gone through
    assign m_wvalid = s_wvalid && w_open;
    assign s_wready = m_wready && w_open;
    assign w_hs        = m_wvalid && m_wready;
    assign w_last_done = w_hs && s_wlast;

    assign b_hs = m_bvalid && s_bready;

    token_bucket #(
        .PER_BEAT_COST (`W_TIMEOUT + 1),
        .BASE_COST     (`B_TIMEOUT)
    ) bucket_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .init_token (init_token),
        .upd_token  (upd_token),
        .len        (s_aw.len),
        .req_valid  (s_awvalid),
        .take       (aw_done),
        .sink_ready (m_awready),
        .refund_a   (w_refund),
        .refund_b   (b_refund),
        .throttled  (aw_throttled)
    );

    write_tracker tracker_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .aw_done     (aw_done),
        .w_last_done (w_last_done),
        .w_open      (w_open),
        .full        (wr_full)
    );

    // Slave ready for data that the master has not sent yet
    refund_timer #(
        .TIMEOUT (`W_TIMEOUT)
    ) w_timer_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .restart (s_wvalid),
        .pending (m_wready && w_open),
        .fire    (w_hs),
        .refund  (w_refund)
    );

    // Response waiting on the master
    refund_timer #(
        .TIMEOUT (`B_TIMEOUT)
    ) b_timer_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .restart (s_bready),
        .pending (m_bvalid),
        .fire    (b_hs),
        .refund  (b_refund)
    );

endmodule

`default_nettype wire

/* design/write_tracker.sv */
`default_nettype none

`include "throttle_params.svh"

module write_tracker (
    input  logic aclk,
    input  logic aresetn,
    input  logic aw_done,
    input  logic w_last_done,
    output logic w_open,
    output logic full
);

    localparam int CNT_W = $clog2(`MAX_OUTST_WR + 1);

    // AWs still waiting for their last data beat
    logic [CNT_W-1:0] outst;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            outst <= '0;
        end else begin
            case ({aw_done, w_last_done})
                2'b10: begin
                    outst <= outst + 1'b1;
                end
                2'b01: begin
                    outst <= outst - 1'b1;
                end
                default: begin
                    // Both or neither, count stays
                    outst <= outst;
                end
            endcase
        end
    end

    assign w_open = outst != '0;
    assign full   = outst == CNT_W'(`MAX_OUTST_WR);

endmodule

`default_nettype wire

/* tests/tb_mem_bw_throttler.sv */
`default_nettype none

`include "throttle_params.svh"

module tb_mem_bw_throttler;

    import throttle_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int WAIT_MAX   = 250;
    localparam logic [`TOK_FRAC_W:0] UPD_RATE = 9'd128;
    // Rough length of each test in cycles
    localparam int TEST_CYCLES = 10 + 80 + 50 + 130 + 200 + 650 + 90;
    localparam int CH_AW = 0;
    localparam int CH_W  = 1;
    localparam int CH_AR = 2;
    localparam int CH_B  = 3;
    localparam int CH_R  = 4;

    logic aclk;
    logic aresetn;
    ax_req_t s_aw, m_aw, s_ar, m_ar;
    w_beat_t s_w, m_w;
    b_resp_t s_b;
    r_beat_t s_r;
    logic s_awvalid, s_awready, m_awvalid, m_awready;
    logic s_wvalid, s_wready, m_wvalid, m_wready;
    logic s_bvalid, s_bready, m_bready;
    logic s_arvalid, s_arready, m_arvalid, m_arready;
    logic s_rvalid, s_rready, m_rready;
    logic [`TOK_INT_W-1:0] aw_init_token, ar_init_token;
    logic [`TOK_FRAC_W:0]  aw_upd_token, ar_upd_token;

    // Driven by the slave model
    b_resp_t              m_b = '0;
    logic                 m_bvalid = 1'b0;
    r_beat_t              m_r = '0;
    logic                 m_rvalid = 1'b0;
    logic [`AXI_ID_W-1:0] last_awid = '0;

    logic [15:0] lfsr = 16'd7740;
    int          test_errors = 0;
    int          total_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    mem_bw_throttler dut_i (.*);

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // Slave model giving one B per W burst and one R beat per AR
    always @(posedge aclk) begin
        if (!aresetn) begin
            m_bvalid <= 1'b0;
            m_rvalid <= 1'b0;
        end else begin
            if (m_awvalid && m_awready) begin
                last_awid <= m_aw.id;
            end
            if (m_bvalid && m_bready) begin
                m_bvalid <= 1'b0;
            end else if (m_wvalid && m_wready && m_w.last) begin
                m_bvalid <= 1'b1;
                m_b      <= '{id: last_awid, resp: 2'b00};
            end
            if (m_rvalid && m_rready) begin
                m_rvalid <= 1'b0;
            end else if (m_arvalid && m_arready) begin
                m_rvalid <= 1'b1;
                m_r      <= '{id: m_ar.id, data: {4{m_ar.addr}}, resp: 2'b00, last: 1'b1};
            end
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic make_req(input logic [7:0] len, output ax_req_t req);
        logic [31:0] v;
        req = '0;
        take_bits(`AXI_ID_W, v);
        req.id = v[`AXI_ID_W-1:0];
        take_bits(`AXI_ADDR_W, v);
        req.addr  = v;
        req.len   = len;
        req.size  = 3'd4;
        req.burst = BURST_INCR;
    endtask

    task automatic report_value(input string test, input logic [159:0] exp,
                                input logic [159:0] act);
        $display("Error %s: expected %0h, actual %0h", test, exp, act);
        test_errors++;
    endtask

    task automatic finish_test(input string test);
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: passed", test);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d bad checks", test, test_errors);
        end
        test_errors = 0;
    endtask

    // Handshake that will complete on the coming rising edge
    function automatic bit hs_seen(input int ch);
        case (ch)
            CH_AW:   return m_awvalid && m_awready;
            CH_W:    return m_wvalid && m_wready;
            CH_AR:   return m_arvalid && m_arready;
            CH_B:    return s_bvalid && s_bready;
            default: return s_rvalid && s_rready;
        endcase
    endfunction

    // Cycles counted from the call and -1 when nothing happened
    task automatic wait_hs(input int ch, input string test, output int cycles);
        cycles = 0;
        do begin
            @(negedge aclk);
            cycles++;
        end while (!hs_seen(ch) && cycles < WAIT_MAX);
        if (!hs_seen(ch)) begin
            $display("%s: no handshake on channel %0d within %0d cycles", test, ch, WAIT_MAX);
            test_errors++;
            cycles = -1;
        end
    endtask

    task automatic drive_idle();
        s_aw      <= '0;
        s_awvalid <= 1'b0;
        s_w       <= '0;
        s_wvalid  <= 1'b0;
        s_bready  <= 1'b1;
        s_ar      <= '0;
        s_arvalid <= 1'b0;
        s_rready  <= 1'b1;
        m_awready <= 1'b1;
        m_wready  <= 1'b1;
        m_arready <= 1'b1;
    endtask

    task automatic do_reset();
        @(posedge aclk);
        aresetn <= 1'b0;
        repeat (2) @(posedge aclk);
        aresetn <= 1'b1;
    endtask

    task automatic send_w_burst(input string test, input int beats);
        w_beat_t     beat;
        logic [31:0] v;
        int          n;
        for (int i = 0; i < beats; i++) begin
            take_bits(32, v);
            beat = '{data: {4{v}}, strb: '1, last: (i == beats - 1)};
            s_w      <= beat;
            s_wvalid <= 1'b1;
            wait_hs(CH_W, test, n);
            if (n > 0 && m_w !== beat) report_value(test, beat, m_w);
            @(posedge aclk);
        end
        s_wvalid <= 1'b0;
    endtask

    task automatic reset_gating();
        @(posedge aclk);
        drive_idle();
        s_awvalid <= 1'b1;
        s_arvalid <= 1'b1;
        s_wvalid  <= 1'b1;
        do_reset();
        @(negedge aclk);
        if (m_awvalid !== 1'b0) report_value("reset_gating", 0, m_awvalid);
        if (s_awready !== 1'b0) report_value("reset_gating", 0, s_awready);
        if (m_arvalid !== 1'b0) report_value("reset_gating", 0, m_arvalid);
        if (s_wready !== 1'b0) report_value("reset_gating", 0, s_wready);
        finish_test("reset_gating");
    endtask

    // Grant time follows from cost over refill rate plus the two-edge bank path
    task automatic grant_timing(input bit is_read);
        string name;
        int    cost;
        int    lo;
        int    n;
        name = is_read ? "ar_grant" : "aw_grant";
        cost = is_read ? (`R_TIMEOUT + 1) : (`W_TIMEOUT + 1 + `B_TIMEOUT);
        lo   = cost * (1 << `TOK_FRAC_W) / int'(UPD_RATE) + 2;
        @(posedge aclk);
        drive_idle();
        if (is_read) s_arvalid <= 1'b1;
        else s_awvalid <= 1'b1;
        do_reset();
        wait_hs(is_read ? CH_AR : CH_AW, name, n);
        if (n >= 0 && (is_read ? s_arready : s_awready) !== 1'b1) begin
            report_value(name, 1, is_read ? s_arready : s_awready);
        end
        @(posedge aclk);
        s_awvalid <= 1'b0;
        s_arvalid <= 1'b0;
        if (n >= 0 && (n < lo || n > lo + 4)) begin
            $display("Error %s: expected grant in %0d..%0d cycles, actual %0d",
                     name, lo, lo + 4, n);
            test_errors++;
        end
        finish_test(name);
    endtask

    task automatic pass_through();
        ax_req_t aw_req;
        ax_req_t ar_req;
        b_resp_t b_exp;
        r_beat_t r_exp;
        int      n;
        @(posedge aclk);
        drive_idle();
        make_req(8'd0, aw_req);
        make_req(8'd0, ar_req);
        b_exp = '{id: aw_req.id, resp: 2'b00};
        r_exp = '{id: ar_req.id, data: {4{ar_req.addr}}, resp: 2'b00, last: 1'b1};
        s_aw      <= aw_req;
        s_awvalid <= 1'b1;
        do_reset();
        wait_hs(CH_AW, "pass_through", n);
        if (m_aw !== aw_req) report_value("pass_through", aw_req, m_aw);
        @(posedge aclk);
        s_awvalid <= 1'b0;
        send_w_burst("pass_through", 1);
        wait_hs(CH_B, "pass_through", n);
        if (n > 0 && s_b !== b_exp) report_value("pass_through", b_exp, s_b);
        if (n > 0 && m_bready !== 1'b1) report_value("pass_through", 1, m_bready);
        @(posedge aclk);
        s_ar      <= ar_req;
        s_arvalid <= 1'b1;
        wait_hs(CH_AR, "pass_through", n);
        if (m_ar !== ar_req) report_value("pass_through", ar_req, m_ar);
        @(posedge aclk);
        s_arvalid <= 1'b0;
        wait_hs(CH_R, "pass_through", n);
        if (n > 0 && s_r !== r_exp) report_value("pass_through", r_exp, s_r);
        if (n > 0 && m_rready !== 1'b1) report_value("pass_through", 1, m_rready);
        finish_test("pass_through");
    endtask

    task automatic w_gating();
        ax_req_t req;
        int      n;
        @(posedge aclk);
        drive_idle();
        make_req(8'd3, req);
        s_aw     <= req;
        s_wvalid <= 1'b1;
        do_reset();
        // Data offered before any AW must stay blocked
        repeat (4) begin
            @(negedge aclk);
            if (m_wvalid !== 1'b0) report_value("w_gating", 0, m_wvalid);
        end
        @(posedge aclk);
        s_awvalid <= 1'b1;
        wait_hs(CH_AW, "w_gating", n);
        @(posedge aclk);
        s_awvalid <= 1'b0;
        send_w_burst("w_gating", int'(req.len) + 1);
        s_wvalid <= 1'b1;
        @(negedge aclk);
        if (m_wvalid !== 1'b0) report_value("w_gating", 0, m_wvalid);
        if (s_wready !== 1'b0) report_value("w_gating", 0, s_wready);
        @(posedge aclk);
        s_wvalid <= 1'b0;
        finish_test("w_gating");
    endtask

    task automatic outstanding_limit();
        int accepted;
        int extra;
        int n;
        @(posedge aclk);
        drive_idle();
        s_awvalid <= 1'b1;
        do_reset();
        accepted = 0;
        while (accepted < `MAX_OUTST_WR) begin
            wait_hs(CH_AW, "outstanding", n);
            if (n < 0) break;
            accepted++;
            @(posedge aclk);
        end
        if (accepted != `MAX_OUTST_WR) report_value("outstanding", `MAX_OUTST_WR, accepted);
        // Long enough to refill the bucket so only the tracker holds AW back
        extra = 0;
        repeat (100) begin
            @(negedge aclk);
            if (hs_seen(CH_AW)) extra++;
        end
        if (extra != 0) report_value("outstanding", `MAX_OUTST_WR, accepted + extra);
        @(posedge aclk);
        send_w_burst("outstanding", 1);
        wait_hs(CH_AW, "outstanding", n);
        @(posedge aclk);
        s_awvalid <= 1'b0;
        finish_test("outstanding");
    endtask

    task automatic ar_backpressure();
        int transfers;
        @(posedge aclk);
        drive_idle();
        m_arready <= 1'b0;
        s_arvalid <= 1'b1;
        do_reset();
        repeat (60) begin
            @(negedge aclk);
            if (s_arready !== 1'b0) report_value("backpressure", 0, s_arready);
        end
        if (m_arvalid !== 1'b1) report_value("backpressure", 1, m_arvalid);
        @(posedge aclk);
        m_arready <= 1'b1;
        transfers = 0;
        repeat (10) begin
            @(negedge aclk);
            if (hs_seen(CH_AR)) transfers++;
            @(posedge aclk);
            if (transfers != 0) s_arvalid <= 1'b0;
        end
        if (transfers != 1) report_value("backpressure", 1, transfers);
        finish_test("backpressure");
    endtask

    initial begin
        aresetn       <= 1'b0;
        aw_init_token <= 16'd1000;
        ar_init_token <= 16'd1000;
        aw_upd_token  <= UPD_RATE;
        ar_upd_token  <= UPD_RATE;
        drive_idle();
        reset_gating();
        grant_timing(1'b0);
        grant_timing(1'b1);
        pass_through();
        w_gating();
        outstanding_limit();
        ar_backpressure();
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d bad checks",
                 tests_run, tests_run - tests_failed, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Twice the expected length of all tests together
    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not end within %0d cycles", 2 * TEST_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+design
design/throttle_pkg.sv
design/refund_timer.sv
design/token_bucket.sv
design/write_tracker.sv
design/write_throttle.sv
design/read_throttle.sv
design/mem_bw_throttler.sv
tests/tb_mem_bw_throttler.sv
